// File: src/exec_pkg.sv
package exec_pkg;

    // datapath widths
    localparam int xlen        = 32;
    localparam int half_xlen   = xlen / 2;
    localparam int tag_width   = 6;
    localparam int mask_width  = 4;
    localparam int imm_width   = 12;
    localparam int cdb_width   = 2;
    localparam int mult_stages = 3;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_sll,
        op_srl,
        op_mul,
        op_mulh,
        op_beq,
        op_bne,
        op_blt,
        op_bge
    } opcode_t;

    typedef enum logic [1:0] {
        unit_alu,
        unit_mult,
        unit_branch
    } unit_t;

    typedef struct packed {
        logic                  valid;
        opcode_t               opcode;
        logic [tag_width-1:0]  dest_tag;
        logic [xlen-1:0]       src_a;
        logic [xlen-1:0]       src_b;
        logic [xlen-1:0]       pc;
        // signed byte offset for branches
        logic [imm_width-1:0]  imm;
        logic                  predicted_taken;
        logic [mask_width-1:0] branch_mask;
        logic [mask_width-1:0] own_mask_bit;
    } issue_packet_t;

    typedef struct packed {
        unit_t         unit;
        issue_packet_t inst;
    } fu_packet_t;

    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] dest_tag;
        logic [xlen-1:0]      value;
    } cdb_packet_t;

    typedef struct packed {
        logic                  valid;
        logic [mask_width-1:0] mask;
        logic                  mispredict;
    } resolve_t;

    typedef struct packed {
        logic                  valid;
        logic                  taken;
        logic [xlen-1:0]       target;
        logic                  mispredict;
        logic [mask_width-1:0] own_mask_bit;
    } branch_result_t;

    // one multiplier pipeline slot
    typedef struct packed {
        logic                  valid;
        logic                  high;
        logic [tag_width-1:0]  dest_tag;
        logic [mask_width-1:0] mask;
        logic [xlen-1:0]       src_a;
        logic [half_xlen-1:0]  b_hi;
        logic [2*xlen-1:0]     product;
    } mult_stage_t;

    // entry depends on a branch that just resolved as mispredicted
    function automatic logic is_squashed(logic [mask_width-1:0] mask, resolve_t res);
        return res.valid && res.mispredict && (|(mask & res.mask));
    endfunction

    // correct resolution frees the branch bit everywhere
    function automatic logic [mask_width-1:0] cleared_mask(logic [mask_width-1:0] mask,
                                                           resolve_t res);
        return (res.valid && !res.mispredict) ? (mask & ~res.mask) : mask;
    endfunction

endpackage

// File: src/issue_decode.sv
`timescale 1ns/1ps

module issue_decode import exec_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  issue_packet_t issue,
    input  resolve_t      resolve,
    output fu_packet_t    alu_in,
    output fu_packet_t    mult_in,
    output fu_packet_t    branch_in
);

    fu_packet_t dec_d;
    fu_packet_t dec_q;
    fu_packet_t fwd;
    logic       opcode_legal;

    // classify and apply resolve on the way in
    always_comb begin
        dec_d                  = '0;
        dec_d.inst             = issue;
        dec_d.inst.valid       = issue.valid && !is_squashed(issue.branch_mask, resolve);
        dec_d.inst.branch_mask = cleared_mask(issue.branch_mask, resolve);
        opcode_legal           = 1'b1;
        case (issue.opcode)
            op_add, op_sub, op_and, op_or,
            op_xor, op_slt, op_sll, op_srl: dec_d.unit = unit_alu;
            op_mul, op_mulh:                dec_d.unit = unit_mult;
            op_beq, op_bne, op_blt, op_bge: dec_d.unit = unit_branch;
            default: begin
                dec_d.unit   = unit_alu;
                opcode_legal = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            dec_q.inst.valid <= 1'b0;
        end else begin
            dec_q <= dec_d;
        end
    end

    // same rule again on the stored entry, so squashed work never leaves
    always_comb begin
        fwd                  = dec_q;
        fwd.inst.valid       = dec_q.inst.valid && !is_squashed(dec_q.inst.branch_mask, resolve);
        fwd.inst.branch_mask = cleared_mask(dec_q.inst.branch_mask, resolve);

        alu_in               = fwd;
        alu_in.inst.valid    = fwd.inst.valid && (fwd.unit == unit_alu);
        mult_in              = fwd;
        mult_in.inst.valid   = fwd.inst.valid && (fwd.unit == unit_mult);
        branch_in            = fwd;
        branch_in.inst.valid = fwd.inst.valid && (fwd.unit == unit_branch);
    end

    a_legal_opcode: assert property (@(posedge clock) disable iff (reset)
        issue.valid |-> opcode_legal);

endmodule

// File: src/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import exec_pkg::*; (
    input  fu_packet_t  alu_in,
    output cdb_packet_t alu_result
);

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [4:0]      shamt;
    logic            lt;

    assign a     = alu_in.inst.src_a;
    assign b     = alu_in.inst.src_b;
    assign shamt = b[4:0];
    // signed compare for slt
    assign lt    = $signed(a) < $signed(b);

    always_comb begin
        alu_result          = '0;
        alu_result.valid    = alu_in.inst.valid;
        alu_result.dest_tag = alu_in.inst.dest_tag;
        case (alu_in.inst.opcode)
            op_add:  alu_result.value = a + b;
            op_sub:  alu_result.value = a - b;
            op_and:  alu_result.value = a & b;
            op_or:   alu_result.value = a | b;
            op_xor:  alu_result.value = a ^ b;
            op_slt:  alu_result.value = {{(xlen-1){1'b0}}, lt};
            op_sll:  alu_result.value = a << shamt;
            // logical shift, zero fill
            op_srl:  alu_result.value = a >> shamt;
            default: alu_result.value = '0;
        endcase
    end

endmodule

// File: src/mult_unit.sv
`timescale 1ns/1ps

module mult_unit import exec_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  fu_packet_t  mult_in,
    input  resolve_t    resolve,
    output cdb_packet_t mult_result
);

    mult_stage_t stage_q [mult_stages];
    mult_stage_t stage_d [mult_stages];

    logic [2*xlen-1:0] a1_ext;
    logic [2*xlen-1:0] lo_ext;
    logic [2*xlen-1:0] a2_ext;
    logic [2*xlen-1:0] hi_ext;

    // b is split into a signed high half and an unsigned low half
    assign a1_ext = {{xlen{mult_in.inst.src_a[xlen-1]}}, mult_in.inst.src_a};
    assign lo_ext = {{(xlen+half_xlen){1'b0}}, mult_in.inst.src_b[half_xlen-1:0]};
    assign a2_ext = {{xlen{stage_q[0].src_a[xlen-1]}}, stage_q[0].src_a};
    assign hi_ext = {{(xlen+half_xlen){stage_q[0].b_hi[half_xlen-1]}}, stage_q[0].b_hi};

    always_comb begin
        // stage 1 takes the low partial product
        stage_d[0].valid    = mult_in.inst.valid
                              && !is_squashed(mult_in.inst.branch_mask, resolve);
        stage_d[0].high     = (mult_in.inst.opcode == op_mulh);
        stage_d[0].dest_tag = mult_in.inst.dest_tag;
        stage_d[0].mask     = cleared_mask(mult_in.inst.branch_mask, resolve);
        stage_d[0].src_a    = mult_in.inst.src_a;
        stage_d[0].b_hi     = mult_in.inst.src_b[xlen-1:half_xlen];
        stage_d[0].product  = a1_ext * lo_ext;

        // stage 2 adds the shifted high partial product
        stage_d[1]          = stage_q[0];
        stage_d[1].product  = stage_q[0].product + ((a2_ext * hi_ext) << half_xlen);

        // stage 3 picks the half of the product that is returned
        stage_d[2]          = stage_q[1];
        stage_d[2].product  = stage_q[1].high ? (stage_q[1].product >> xlen)
                                              : stage_q[1].product;

        for (int i = 1; i < mult_stages; i++) begin
            stage_d[i].valid = stage_q[i-1].valid && !is_squashed(stage_q[i-1].mask, resolve);
            stage_d[i].mask  = cleared_mask(stage_q[i-1].mask, resolve);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < mult_stages; i++) begin
            if (reset) begin
                stage_q[i].valid <= 1'b0;
            end else begin
                stage_q[i] <= stage_d[i];
            end
        end
    end

    assign mult_result.valid    = stage_q[mult_stages-1].valid
                                  && !is_squashed(stage_q[mult_stages-1].mask, resolve);
    assign mult_result.dest_tag = stage_q[mult_stages-1].dest_tag;
    assign mult_result.value    = stage_q[mult_stages-1].product[xlen-1:0];

    // decode routes only multiplies here
    a_stage0_src: assert property (@(posedge clock) disable iff (reset)
        stage_q[0].valid |-> $past(mult_in.inst.opcode inside {op_mul, op_mulh}));
    // a slot only fills from the slot behind it
    for (genvar g = 1; g < mult_stages; g++) begin : g_stage_chk
        a_stage_src: assert property (@(posedge clock) disable iff (reset)
            stage_q[g].valid |-> $past(stage_q[g-1].valid));
    end

endmodule

// File: src/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import exec_pkg::*; (
    input  fu_packet_t     branch_in,
    output branch_result_t branch_comb,
    output cdb_packet_t    branch_link
);

    logic            eq;
    logic            lt;
    logic            taken;
    logic [xlen-1:0] offset;
    logic [xlen-1:0] pc_next;

    assign eq      = branch_in.inst.src_a == branch_in.inst.src_b;
    assign lt      = $signed(branch_in.inst.src_a) < $signed(branch_in.inst.src_b);
    assign offset  = {{(xlen-imm_width){branch_in.inst.imm[imm_width-1]}}, branch_in.inst.imm};
    assign pc_next = branch_in.inst.pc + xlen'(4);

    always_comb begin
        case (branch_in.inst.opcode)
            op_beq:  taken = eq;
            op_bne:  taken = !eq;
            op_blt:  taken = lt;
            op_bge:  taken = !lt;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        branch_comb.valid        = branch_in.inst.valid;
        branch_comb.taken        = taken;
        branch_comb.target       = taken ? (branch_in.inst.pc + offset) : pc_next;
        branch_comb.mispredict   = taken != branch_in.inst.predicted_taken;
        branch_comb.own_mask_bit = branch_in.inst.own_mask_bit;
    end

    // link value wakes up the branch's destination tag
    assign branch_link.valid    = branch_in.inst.valid;
    assign branch_link.dest_tag = branch_in.inst.dest_tag;
    assign branch_link.value    = pc_next;

endmodule

// File: src/complete_select.sv
`timescale 1ns/1ps

module complete_select import exec_pkg::*; (
    input  logic                           clock,
    input  logic                           reset,
    input  cdb_packet_t                    alu_result,
    input  cdb_packet_t                    mult_result,
    input  cdb_packet_t                    branch_link,
    input  branch_result_t                 branch_comb,
    output cdb_packet_t [cdb_width-1:0]    cdb,
    output branch_result_t                 branch_out
);

    cdb_packet_t                 single;
    cdb_packet_t [cdb_width-1:0] cdb_d;
    int unsigned                 free_lane;

    // alu and branch never finish together, decode routes one at a time
    assign single = alu_result.valid ? alu_result : branch_link;

    always_comb begin
        cdb_d     = '0;
        free_lane = 0;
        if (single.valid) begin
            cdb_d[0]  = single;
            free_lane = 1;
        end
        // multiplier takes the next free lane
        if (mult_result.valid && (free_lane < cdb_width)) begin
            cdb_d[free_lane] = mult_result;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < cdb_width; i++) begin
                cdb[i].valid <= 1'b0;
            end
            branch_out.valid <= 1'b0;
        end else begin
            cdb        <= cdb_d;
            branch_out <= branch_comb;
        end
    end

    a_lane_budget: assert property (@(posedge clock) disable iff (reset)
        $countones({alu_result.valid, mult_result.valid, branch_link.valid}) <= cdb_width);

endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import exec_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  issue_packet_t               issue,
    input  resolve_t                    resolve,
    output cdb_packet_t [cdb_width-1:0] cdb,
    output branch_result_t              branch_out
);

    fu_packet_t     alu_in;
    fu_packet_t     mult_in;
    fu_packet_t     branch_in;
    cdb_packet_t    alu_result;
    cdb_packet_t    mult_result;
    cdb_packet_t    branch_link;
    branch_result_t branch_comb;

    issue_decode u_decode (
        .clock     (clock),
        .reset     (reset),
        .issue     (issue),
        .resolve   (resolve),
        .alu_in    (alu_in),
        .mult_in   (mult_in),
        .branch_in (branch_in)
    );

    alu_unit u_alu (
        .alu_in     (alu_in),
        .alu_result (alu_result)
    );

    // three cycle pipeline, sees resolve on every stage
    mult_unit u_mult (
        .clock       (clock),
        .reset       (reset),
        .mult_in     (mult_in),
        .resolve     (resolve),
        .mult_result (mult_result)
    );

    branch_unit u_branch (
        .branch_in   (branch_in),
        .branch_comb (branch_comb),
        .branch_link (branch_link)
    );

    complete_select u_complete (
        .clock       (clock),
        .reset       (reset),
        .alu_result  (alu_result),
        .mult_result (mult_result),
        .branch_link (branch_link),
        .branch_comb (branch_comb),
        .cdb         (cdb),
        .branch_out  (branch_out)
    );

endmodule

// File: verif/exec_checker.sv
`timescale 1ns/1ps

module exec_checker import exec_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  issue_packet_t               issue,
    input  cdb_packet_t [cdb_width-1:0] cdb,
    input  branch_result_t              branch_out,
    input  logic                        exp_squash,
    input  logic [xlen-1:0]             exp_value,
    input  logic                        exp_taken,
    input  logic [xlen-1:0]             exp_target,
    input  logic                        exp_mispredict,
    output int                          errors,
    output int                          passed,
    output int                          outstanding
);

    localparam int alu_latency  = 2;
    localparam int mult_latency = 5;
    localparam int tag_count    = 2**tag_width;

    // one expected record per destination tag
    typedef struct packed {
        logic                  pending;
        logic                  squash;
        logic                  is_mult;
        logic                  is_branch;
        logic                  taken;
        logic                  mispredict;
        logic [mask_width-1:0] own_bit;
        logic [xlen-1:0]       value;
        logic [xlen-1:0]       target;
        int                    due;
    } expect_t;

    expect_t book [tag_count];
    int      cycle       = 0;
    int      err_count   = 0;
    int      pass_count  = 0;
    int      open_count  = 0;
    logic    entry_ok;
    logic    branch_seen;
    logic    single_due;

    assign errors      = err_count;
    assign passed      = pass_count;
    assign outstanding = open_count;

    function automatic logic is_mult_op(opcode_t op);
        return (op == op_mul) || (op == op_mulh);
    endfunction

    function automatic logic is_branch_op(opcode_t op);
        return (op == op_beq) || (op == op_bne) || (op == op_blt) || (op == op_bge);
    endfunction

    task automatic check_value(string name, logic [xlen-1:0] expected, logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("error at %0d ns: %s expected %h got %h", $time, name, expected, actual);
            err_count++;
            entry_ok = 1'b0;
        end
    endtask

    task automatic check_completion(int lane, logic [tag_width-1:0] tag);
        expect_t e;
        int      exp_lane;
        e        = book[tag];
        entry_ok = 1'b1;
        if (!e.pending) begin
            $display("tag %0h appeared on cdb lane %0d with no outstanding issue", tag, lane);
            err_count++;
        end else if (e.squash) begin
            $display("tag %0h completed on cdb lane %0d but should have been squashed", tag, lane);
            err_count++;
            book[tag].pending = 1'b0;
        end else begin
            // multiply takes lane 1 only when a single-cycle result is due too
            exp_lane = (e.is_mult && single_due) ? 1 : 0;
            check_value($sformatf("cdb lane of tag %0h", tag), exp_lane, lane);
            check_value($sformatf("cdb[%0d] cycle of tag %0h", lane, tag), e.due, cycle);
            check_value($sformatf("cdb[%0d].value", lane), e.value, cdb[lane].value);
            if (e.is_branch) begin
                branch_seen = 1'b1;
                check_value("branch_out.valid", 1, branch_out.valid);
                check_value("branch_out.taken", e.taken, branch_out.taken);
                check_value("branch_out.target", e.target, branch_out.target);
                check_value("branch_out.mispredict", e.mispredict, branch_out.mispredict);
                check_value("branch_out.own_mask_bit", e.own_bit, branch_out.own_mask_bit);
            end
            if (entry_ok) begin
                $display("tag %0h passed on cdb[%0d], value %h", tag, lane, cdb[lane].value);
                pass_count++;
            end
            book[tag].pending = 1'b0;
        end
    endtask

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // outputs are sampled mid cycle, away from the active edge
    always @(negedge clock) begin
        if (reset) begin
            for (int i = 0; i < cdb_width; i++) begin
                check_value($sformatf("cdb[%0d].valid in reset", i), '0, cdb[i].valid);
            end
            check_value("branch_out.valid in reset", '0, branch_out.valid);
            for (int i = 0; i < tag_count; i++) begin
                book[i].pending = 1'b0;
            end
        end else begin
            branch_seen = 1'b0;
            // an alu or branch result owed this cycle claims lane 0
            single_due  = 1'b0;
            for (int i = 0; i < tag_count; i++) begin
                if (book[i].pending && !book[i].squash && !book[i].is_mult
                    && book[i].due == cycle) begin
                    single_due = 1'b1;
                end
            end
            for (int l = 0; l < cdb_width; l++) begin
                if (cdb[l].valid) begin
                    check_completion(l, cdb[l].dest_tag);
                end
            end
            if (branch_out.valid && !branch_seen) begin
                $display("branch_out went valid at %0d ns with no branch tag on the cdb", $time);
                err_count++;
            end
            // anything still open at its due cycle never made it
            for (int i = 0; i < tag_count; i++) begin
                if (book[i].pending && book[i].due <= cycle) begin
                    if (book[i].squash) begin
                        $display("tag %0h squashed, never completed", i);
                        pass_count++;
                    end else begin
                        $display("tag %0h did not complete by cycle %0d", i, book[i].due);
                        err_count++;
                    end
                    book[i].pending = 1'b0;
                end
            end
            if (issue.valid) begin
                if (book[issue.dest_tag].pending) begin
                    $display("tag %0h issued again while still outstanding", issue.dest_tag);
                    err_count++;
                end
                book[issue.dest_tag].pending    = 1'b1;
                book[issue.dest_tag].squash     = exp_squash;
                book[issue.dest_tag].is_mult    = is_mult_op(issue.opcode);
                book[issue.dest_tag].is_branch  = is_branch_op(issue.opcode);
                book[issue.dest_tag].taken      = exp_taken;
                book[issue.dest_tag].mispredict = exp_mispredict;
                book[issue.dest_tag].own_bit    = issue.own_mask_bit;
                book[issue.dest_tag].value      = exp_value;
                book[issue.dest_tag].target     = exp_target;
                book[issue.dest_tag].due        = cycle + (is_mult_op(issue.opcode)
                                                           ? mult_latency : alu_latency);
            end
        end
        open_count = 0;
        for (int i = 0; i < tag_count; i++) begin
            open_count += book[i].pending ? 1 : 0;
        end
    end

endmodule

// File: verif/exec_tb.sv
`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

    localparam int words_per_line = 18;
    localparam int trace_depth    = 1024;
    localparam int drain_limit    = 40;

    logic                        clock;
    logic                        reset;
    issue_packet_t               issue;
    resolve_t                    resolve;
    cdb_packet_t [cdb_width-1:0] cdb;
    branch_result_t              branch_out;

    // expected outcome of the instruction currently on issue
    logic                        exp_squash;
    logic [xlen-1:0]             exp_value;
    logic                        exp_taken;
    logic [xlen-1:0]             exp_target;
    logic                        exp_mispredict;

    int                          errors;
    int                          passed;
    int                          outstanding;
    logic [31:0]                 trace_mem [trace_depth];
    int                          line_count;
    bit                          trace_ok;
    int                          wait_cycles;

    execute_stage DUT (
        .clock      (clock),
        .reset      (reset),
        .issue      (issue),
        .resolve    (resolve),
        .cdb        (cdb),
        .branch_out (branch_out)
    );

    exec_checker u_checker (
        .clock          (clock),
        .reset          (reset),
        .issue          (issue),
        .cdb            (cdb),
        .branch_out     (branch_out),
        .exp_squash     (exp_squash),
        .exp_value      (exp_value),
        .exp_taken      (exp_taken),
        .exp_target     (exp_target),
        .exp_mispredict (exp_mispredict),
        .errors         (errors),
        .passed         (passed),
        .outstanding    (outstanding)
    );

    always #2 clock = ~clock;

    task automatic drive_idle();
        issue          = '0;
        resolve        = '0;
        exp_squash     = 1'b0;
        exp_value      = '0;
        exp_taken      = 1'b0;
        exp_target     = '0;
        exp_mispredict = 1'b0;
    endtask

    // word 0 of the trace is the line count
    task automatic drive_line(int n);
        int b;
        b                     = 1 + n * words_per_line;
        issue.valid           = trace_mem[b][0];
        issue.opcode          = opcode_t'(trace_mem[b+1][3:0]);
        issue.dest_tag        = trace_mem[b+2][tag_width-1:0];
        issue.src_a           = trace_mem[b+3];
        issue.src_b           = trace_mem[b+4];
        issue.pc              = trace_mem[b+5];
        issue.imm             = trace_mem[b+6][imm_width-1:0];
        issue.predicted_taken = trace_mem[b+7][0];
        issue.branch_mask     = trace_mem[b+8][mask_width-1:0];
        issue.own_mask_bit    = trace_mem[b+9][mask_width-1:0];
        resolve.valid         = trace_mem[b+10][0];
        resolve.mask          = trace_mem[b+11][mask_width-1:0];
        resolve.mispredict    = trace_mem[b+12][0];
        exp_squash            = trace_mem[b+13][0];
        exp_value             = trace_mem[b+14];
        exp_taken             = trace_mem[b+15][0];
        exp_target            = trace_mem[b+16];
        exp_mispredict        = trace_mem[b+17][0];
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        drive_idle();
        $readmemh("verif/exec_trace.txt", trace_mem);
        line_count = trace_mem[0];
        trace_ok   = !$isunknown(trace_mem[0]) && (line_count > 0)
                     && ((1 + line_count * words_per_line) <= trace_depth);
        repeat (8) @(posedge clock);
        #1 reset = 1'b0;
        if (trace_ok) begin
            for (int n = 0; n < line_count; n++) begin
                @(posedge clock);
                #1 drive_line(n);
            end
        end else begin
            $display("trace file verif/exec_trace.txt is missing or malformed");
        end
        @(posedge clock);
        #1 drive_idle();
        // drain whatever is still in flight, counts settle at the falling edge
        wait_cycles = 0;
        while (outstanding != 0 && wait_cycles < drain_limit) begin
            @(posedge clock);
            wait_cycles++;
        end
        if (outstanding != 0) begin
            $display("timed out waiting for %0d outstanding tags to drain", outstanding);
        end
        $display("%0d passed, %0d errors, %0d outstanding", passed, errors, outstanding);
        if (trace_ok && errors == 0 && outstanding == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verif/exec_trace.txt
// line count, then per issue cycle: valid opcode tag src_a src_b pc imm pred mask own
// res_valid res_mask res_mispredict | squashed value taken target mispredict
1d
1 0 01 5 7 0 0 0 0 0 0 0 0 0 c 0 0 0
1 1 02 3 5 0 0 0 0 0 0 0 0 0 fffffffe 0 0 0
1 2 03 f0f0 ff00 0 0 0 0 0 0 0 0 0 f000 0 0 0
1 3 04 f0f0 0f0f 0 0 0 0 0 0 0 0 0 ffff 0 0 0
1 4 05 ffff 0ff0 0 0 0 0 0 0 0 0 0 f00f 0 0 0
1 5 06 ffffffff 1 0 0 0 0 0 0 0 0 0 1 0 0 0
1 6 07 1 24 0 0 0 0 0 0 0 0 0 10 0 0 0
1 7 08 80000000 1f 0 0 0 0 0 0 0 0 0 1 0 0 0
1 8 09 3 fffffffe 0 0 0 0 0 0 0 0 0 fffffffa 0 0 0
1 9 0a fffffffe 3 0 0 0 0 0 0 0 0 0 ffffffff 0 0 0
1 9 0b 10000 10000 0 0 0 0 0 0 0 0 0 1 0 0 0
1 0 0c 1 1 0 0 0 0 0 0 0 0 0 2 0 0 0
1 4 0d aaaa5555 ffffffff 0 0 0 0 0 0 0 0 0 5555aaaa 0 0 0
1 a 0e 5 5 100 010 1 0 1 0 0 0 0 104 1 110 0
1 b 0f 5 5 200 020 1 0 2 0 0 0 0 204 0 204 1
1 c 10 ffffffff 1 300 ff0 0 0 4 0 0 0 0 304 1 2f0 1
1 d 11 1 ffffffff 400 008 1 0 8 0 0 0 0 404 1 408 0
1 a 12 1 2 500 040 1 0 1 0 0 0 0 504 0 504 1
1 8 13 2 3 0 0 0 1 0 0 0 0 1 6 0 0 0
1 9 14 80000000 2 0 0 0 0 0 0 0 0 0 ffffffff 0 0 0
1 2 15 ff 0f 0 0 0 1 0 0 0 0 1 f 0 0 0
1 1 16 9 1 0 0 0 1 0 1 1 1 1 8 0 0 0
1 0 17 1 2 0 0 0 0 0 0 0 0 0 3 0 0 0
1 b 18 1 2 600 020 1 0 2 0 0 0 0 604 1 620 0
1 8 19 7 6 0 0 0 2 0 0 0 0 0 2a 0 0 0
1 0 1a 4 4 0 0 0 2 0 1 2 0 0 8 0 0 0
1 a 1b 3 3 700 010 0 0 2 0 0 0 0 704 1 710 1
1 3 1c 1 2 0 0 0 2 0 0 0 0 1 3 0 0 0
0 0 00 0 0 0 0 0 0 0 1 2 1 0 0 0 0 0

// File: all.f
src/exec_pkg.sv
src/issue_decode.sv
src/alu_unit.sv
src/mult_unit.sv
src/branch_unit.sv
src/complete_select.sv
src/execute_stage.sv
verif/exec_checker.sv
verif/exec_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module exec_tb \
		-f all.f -Mdir obj_dir -o exec_sim
	@out="$$(./obj_dir/exec_sim)"; echo "$$out"; \
		echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
